/* uf_defs.svh */
`ifndef UF_DEFS_SVH
`define UF_DEFS_SVH

// ##################################################
// Decoder sizing

// Number of processing units, one edge to the left of each
`define UF_CHAIN_LENGTH 8

// Merge and peeling wait this many extra cycles before trusting the
// registered busy flag, which lags the units by two cycles
`define UF_MAXIMUM_DELAY 2

// ##################################################
// Counter widths

`define UF_ITERATION_WIDTH 8
`define UF_CYCLE_WIDTH 32

`endif

/* uf_pkg.sv */
`include "uf_defs.svh"

package uf_pkg;

    // Global decoding stage, shared by the controller and every unit
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_PEELING             = 3'd4,
        STAGE_RESULT_VALID        = 3'd5
    } stage_t;

    // One defect bit per unit
    typedef logic [`UF_CHAIN_LENGTH-1:0] syndrome_t;

    // Bit i is the edge to the left of unit i, bit 0 runs to the boundary
    typedef logic [`UF_CHAIN_LENGTH-1:0] correction_t;

    typedef logic [`UF_CHAIN_LENGTH-1:0] unit_flags_t;

    typedef logic [`UF_ITERATION_WIDTH-1:0] iteration_t;
    typedef logic [`UF_CYCLE_WIDTH-1:0] cycle_t;

endpackage

/* uf_array_if.sv */
`timescale 1ns/1ps

interface uf_array_if;

    uf_pkg::stage_t      stage;
    uf_pkg::syndrome_t   syndrome;
    uf_pkg::unit_flags_t busy_pe;
    uf_pkg::unit_flags_t odd_pe;
    uf_pkg::correction_t correction;

    modport controller (
        output stage,
        input  busy_pe,
        input  odd_pe
    );

    modport intake (
        output syndrome
    );

    // The unit chain sees the stage and the syndrome and reports back
    modport array (
        input  stage,
        input  syndrome,
        output busy_pe,
        output odd_pe,
        output correction
    );

endinterface

/* syndrome_intake.sv */
`timescale 1ns/1ps

module syndrome_intake (
    input  logic              clk,
    input  logic              reset,
    input  logic              syndrome_req,
    input  uf_pkg::syndrome_t syndrome_in,
    output logic              syndrome_ack,
    output logic              new_round_start,
    uf_array_if.intake        bus,
    input  logic              idle
);

    typedef enum logic {
        ACK_LOW,
        ACK_HIGH
    } ack_state_t;

    ack_state_t ack_state;
    logic       accept;

    // A request is only taken while the decoder sits idle
    assign accept = (ack_state == ACK_LOW) && syndrome_req && idle;

    assign syndrome_ack = (ack_state == ACK_HIGH);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_state <= ACK_LOW;
            new_round_start <= 1'b0;
        end else begin
            new_round_start <= 1'b0;
            case (ack_state)
                ACK_LOW: begin
                    if (accept) begin
                        ack_state <= ACK_HIGH;
                        new_round_start <= 1'b1;
                    end
                end
                ACK_HIGH: begin
                    // Hold ack until the sender lets go of req
                    if (!syndrome_req) begin
                        ack_state <= ACK_LOW;
                    end
                end
                default: begin
                    ack_state <= ACK_LOW;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus.syndrome <= syndrome_in;
        end
    end

endmodule

/* unified_controller.sv */
`timescale 1ns/1ps
`include "uf_defs.svh"

module unified_controller (
    input  logic               clk,
    input  logic               reset,
    input  logic               new_round_start,
    uf_array_if.controller     bus,
    output logic               idle,
    output logic               result_valid,
    output uf_pkg::iteration_t iteration_count,
    output uf_pkg::cycle_t     cycle_count
);

    localparam int DELAY_WIDTH = $clog2(`UF_MAXIMUM_DELAY + 1);

    uf_pkg::stage_t         stage;
    logic [DELAY_WIDTH-1:0] delay_count;
    logic                   busy_any;
    logic                   odd_any;

    assign bus.stage = stage;
    assign idle = (stage == uf_pkg::STAGE_IDLE);

    // ##################################################
    // Registered summary of the unit flags

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_any <= 1'b0;
            odd_any <= 1'b0;
        end else begin
            busy_any <= |bus.busy_pe;
            odd_any <= |bus.odd_pe;
        end
    end

    // ##################################################
    // Round statistics

    // Grow lasts a single cycle, so every grow cycle is a fresh entry
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
        end else if (stage == uf_pkg::STAGE_MEASUREMENT_LOADING) begin
            iteration_count <= '0;
        end else if (stage == uf_pkg::STAGE_GROW) begin
            iteration_count <= iteration_count + 1'b1;
        end
    end

    // Counts every cycle of a round, loading included
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else if (stage == uf_pkg::STAGE_MEASUREMENT_LOADING) begin
            cycle_count <= uf_pkg::cycle_t'(1);
        end else if (!result_valid && stage != uf_pkg::STAGE_IDLE) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // ##################################################
    // Stage sequence

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= uf_pkg::STAGE_IDLE;
            delay_count <= '0;
            result_valid <= 1'b0;
        end else begin
            case (stage)
                uf_pkg::STAGE_IDLE: begin
                    if (new_round_start) begin
                        stage <= uf_pkg::STAGE_MEASUREMENT_LOADING;
                        delay_count <= '0;
                        result_valid <= 1'b0;
                    end
                end
                uf_pkg::STAGE_MEASUREMENT_LOADING: begin
                    stage <= uf_pkg::STAGE_GROW;
                    delay_count <= '0;
                end
                uf_pkg::STAGE_GROW: begin
                    stage <= uf_pkg::STAGE_MERGE;
                    delay_count <= '0;
                end
                uf_pkg::STAGE_MERGE: begin
                    // Busy and odd are stale until the guard has expired
                    if (delay_count >= `UF_MAXIMUM_DELAY) begin
                        if (!busy_any) begin
                            delay_count <= '0;
                            if (odd_any) begin
                                stage <= uf_pkg::STAGE_GROW;
                            end else begin
                                stage <= uf_pkg::STAGE_PEELING;
                            end
                        end
                    end else begin
                        delay_count <= delay_count + 1'b1;
                    end
                end
                uf_pkg::STAGE_PEELING: begin
                    if (delay_count >= `UF_MAXIMUM_DELAY) begin
                        if (!busy_any) begin
                            stage <= uf_pkg::STAGE_RESULT_VALID;
                            delay_count <= '0;
                        end
                    end else begin
                        delay_count <= delay_count + 1'b1;
                    end
                end
                uf_pkg::STAGE_RESULT_VALID: begin
                    stage <= uf_pkg::STAGE_IDLE;
                    result_valid <= 1'b1;
                end
                default: begin
                    stage <= uf_pkg::STAGE_IDLE;
                end
            endcase
        end
    end

endmodule

/* processing_unit.sv */
`timescale 1ns/1ps

module processing_unit #(
    parameter bit left_boundary = 1'b0,
    parameter bit right_end = 1'b0
) (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_t stage,
    input  logic           defect,
    input  logic           left_occupied,
    input  logic           left_odd,
    input  logic           right_occupied,
    input  logic           right_odd,
    input  logic           right_suffix_parity,
    output logic           occupied,
    output logic           cluster_odd,
    output logic           suffix_parity,
    output logic           busy,
    output logic           correction
);

    logic left_link;
    logic right_link;
    logic grow_request;
    logic suffix_next;
    logic odd_next;
    logic correction_next;

    // Only a real neighbour takes part, the chain ends have none
    assign left_link = !left_boundary && left_occupied;
    assign right_link = !right_end && right_occupied;

    assign grow_request = (left_link && left_odd) || (right_link && right_odd);

    // Parity of the defects from this unit to the right end of its cluster
    assign suffix_next = defect ^ (right_link && right_suffix_parity);

    // The leftmost unit of a cluster decides its oddness and passes it right.
    // A cluster touching the boundary can always be matched there
    always_comb begin
        if (left_link) begin
            odd_next = left_odd;
        end else if (left_boundary) begin
            odd_next = 1'b0;
        end else begin
            odd_next = suffix_parity;
        end
    end

    assign correction_next = occupied && suffix_parity;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= 1'b0;
            cluster_odd <= 1'b0;
            suffix_parity <= 1'b0;
            busy <= 1'b0;
            correction <= 1'b0;
        end else begin
            busy <= 1'b0;
            case (stage)
                uf_pkg::STAGE_MEASUREMENT_LOADING: begin
                    occupied <= defect;
                    cluster_odd <= 1'b0;
                    suffix_parity <= 1'b0;
                end
                uf_pkg::STAGE_GROW: begin
                    if (!occupied && grow_request) begin
                        occupied <= 1'b1;
                    end
                end
                uf_pkg::STAGE_MERGE: begin
                    if (occupied) begin
                        suffix_parity <= suffix_next;
                        cluster_odd <= odd_next;
                        busy <= (suffix_next != suffix_parity) || (odd_next != cluster_odd);
                    end
                end
                uf_pkg::STAGE_PEELING: begin
                    correction <= correction_next;
                    busy <= (correction_next != correction);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* pu_chain.sv */
`timescale 1ns/1ps
`include "uf_defs.svh"

module pu_chain (
    input  logic      clk,
    input  logic      reset,
    uf_array_if.array bus
);

    localparam int N = `UF_CHAIN_LENGTH;

    uf_pkg::unit_flags_t occupied;
    uf_pkg::unit_flags_t cluster_odd;
    uf_pkg::unit_flags_t suffix_parity;
    uf_pkg::unit_flags_t left_occupied;
    uf_pkg::unit_flags_t left_odd;
    uf_pkg::unit_flags_t right_occupied;
    uf_pkg::unit_flags_t right_odd;
    uf_pkg::unit_flags_t right_suffix_parity;

    // Neighbour views, shifted in a zero where the chain ends
    assign left_occupied = {occupied[N-2:0], 1'b0};
    assign left_odd = {cluster_odd[N-2:0], 1'b0};
    assign right_occupied = {1'b0, occupied[N-1:1]};
    assign right_odd = {1'b0, cluster_odd[N-1:1]};
    assign right_suffix_parity = {1'b0, suffix_parity[N-1:1]};

    // Oddness only counts for sites inside a cluster
    assign bus.odd_pe = cluster_odd & occupied;

    for (genvar i = 0; i < N; i++) begin : g_unit
        processing_unit #(
            .left_boundary(i == 0),
            .right_end(i == N - 1)
        ) pu (
            .clk                (clk),
            .reset              (reset),
            .stage              (bus.stage),
            .defect             (bus.syndrome[i]),
            .left_occupied      (left_occupied[i]),
            .left_odd           (left_odd[i]),
            .right_occupied     (right_occupied[i]),
            .right_odd          (right_odd[i]),
            .right_suffix_parity(right_suffix_parity[i]),
            .occupied           (occupied[i]),
            .cluster_odd        (cluster_odd[i]),
            .suffix_parity      (suffix_parity[i]),
            .busy               (bus.busy_pe[i]),
            .correction         (bus.correction[i])
        );
    end

endmodule

/* uf_decoder_top.sv */
`timescale 1ns/1ps

module uf_decoder_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                syndrome_req,
    input  uf_pkg::syndrome_t   syndrome_in,
    output logic                syndrome_ack,
    output logic                result_valid,
    output uf_pkg::correction_t correction,
    output uf_pkg::iteration_t  iteration_count,
    output uf_pkg::cycle_t      cycle_count
);

    logic new_round_start;
    logic idle;

    uf_array_if array_bus ();

    assign correction = array_bus.correction;

    syndrome_intake intake0 (
        .clk            (clk),
        .reset          (reset),
        .syndrome_req   (syndrome_req),
        .syndrome_in    (syndrome_in),
        .syndrome_ack   (syndrome_ack),
        .new_round_start(new_round_start),
        .bus            (array_bus.intake),
        .idle           (idle)
    );

    unified_controller controller0 (
        .clk            (clk),
        .reset          (reset),
        .new_round_start(new_round_start),
        .bus            (array_bus.controller),
        .idle           (idle),
        .result_valid   (result_valid),
        .iteration_count(iteration_count),
        .cycle_count    (cycle_count)
    );

    pu_chain chain0 (
        .clk  (clk),
        .reset(reset),
        .bus  (array_bus.array)
    );

endmodule

/* uf_decoder_sva.sv */
`timescale 1ns/1ps
`include "uf_defs.svh"

module uf_decoder_sva (
    input logic           clk,
    input logic           reset,
    input logic           syndrome_req,
    input logic           syndrome_ack,
    input logic           result_valid,
    input uf_pkg::stage_t stage
);

    int assertion_failures = 0;

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(syndrome_ack) |-> $past(syndrome_req))
        else begin
            assertion_failures++;
            $error("syndrome_ack rose without syndrome_req");
        end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(syndrome_ack) |-> !$past(syndrome_req))
        else begin
            assertion_failures++;
            $error("syndrome_ack fell while syndrome_req was still high");
        end

    // Results are hidden for the whole active part of a round
    valid_low_in_round: assert property (@(posedge clk) disable iff (reset)
        (stage inside {uf_pkg::STAGE_MEASUREMENT_LOADING, uf_pkg::STAGE_GROW,
                       uf_pkg::STAGE_MERGE, uf_pkg::STAGE_PEELING}) |-> !result_valid)
        else begin
            assertion_failures++;
            $error("result_valid high during an active round");
        end

    merge_guarded: assert property (@(posedge clk) disable iff (reset)
        (stage == uf_pkg::STAGE_GROW) |=>
            (stage == uf_pkg::STAGE_MERGE) [*(`UF_MAXIMUM_DELAY + 1)])
        else begin
            assertion_failures++;
            $error("merge left before the delay guard expired");
        end

endmodule

bind uf_decoder_top uf_decoder_sva protocol_checks0 (
    .clk         (clk),
    .reset       (reset),
    .syndrome_req(syndrome_req),
    .syndrome_ack(syndrome_ack),
    .result_valid(result_valid),
    .stage       (array_bus.stage)
);

/* tb_uf_decoder.sv */
`timescale 1ns/1ps
`include "uf_defs.svh"

module tb_uf_decoder;

    localparam int N = `UF_CHAIN_LENGTH;
    localparam int CLOCK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 1;
    localparam int RANDOM_ROUNDS = 200;
    localparam int TOTAL_ROUNDS = RANDOM_ROUNDS + 4;
    localparam longint TIMEOUT_NS = longint'(TOTAL_ROUNDS) * N * 40 * CLOCK_PERIOD;

    logic                clk;
    logic                reset;
    logic                syndrome_req;
    uf_pkg::syndrome_t   syndrome_in;
    logic                syndrome_ack;
    logic                result_valid;
    uf_pkg::correction_t correction;
    uf_pkg::iteration_t  iteration_count;
    uf_pkg::cycle_t      cycle_count;

    int                  error_count;
    uf_pkg::cycle_t      idle_cycles;
    int unsigned         cycle_number;
    int unsigned         ack_cycle;

    uf_decoder_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .syndrome_req   (syndrome_req),
        .syndrome_in    (syndrome_in),
        .syndrome_ack   (syndrome_ack),
        .result_valid   (result_valid),
        .correction     (correction),
        .iteration_count(iteration_count),
        .cycle_count    (cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    function automatic int total_errors();
        return error_count + dut0.protocol_checks0.assertion_failures;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // Inputs change a little after the rising edge, outputs are settled by then
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
        cycle_number++;
    endtask

    // ##################################################
    // Reference model of grow, merge and peel

    task automatic predict(input uf_pkg::syndrome_t s, output uf_pkg::correction_t corr,
                           output int iterations);
        logic [N-1:0] occ;
        logic [N-1:0] grown;
        logic [N-1:0] odd;
        logic [N-1:0] suffix;
        logic         parity;
        logic         start_odd;
        logic         any_odd;
        occ = s;
        odd = '0;
        iterations = 0;
        any_odd = 1'b1;
        while (any_odd) begin
            iterations++;
            grown = occ;
            for (int i = 0; i < N; i++) begin
                if (!occ[i] && i > 0 && occ[i-1] && odd[i-1]) grown[i] = 1'b1;
                if (!occ[i] && i < N - 1 && occ[i+1] && odd[i+1]) grown[i] = 1'b1;
            end
            occ = grown;
            parity = 1'b0;
            for (int i = N - 1; i >= 0; i--) begin
                parity = occ[i] ? (parity ^ s[i]) : 1'b0;
                suffix[i] = parity;
            end
            // The left end of a cluster sets its oddness, the boundary absorbs any parity
            start_odd = 1'b0;
            any_odd = 1'b0;
            for (int i = 0; i < N; i++) begin
                if (occ[i] && (i == 0 || !occ[i-1])) start_odd = (i == 0) ? 1'b0 : suffix[i];
                odd[i] = occ[i] && start_odd;
                any_odd |= odd[i];
            end
        end
        corr = occ & suffix;
    endtask

    // ##################################################
    // Handshake driver and round checks

    task automatic send_syndrome(input uf_pkg::syndrome_t s);
        int gap;
        gap = $urandom_range(0, 3);
        repeat (gap) next_cycle();
        compare_value("cycle_count", idle_cycles, cycle_count);
        syndrome_in = s;
        syndrome_req = 1'b1;
        do next_cycle(); while (!syndrome_ack);
        ack_cycle = cycle_number;
        syndrome_req = 1'b0;
        do next_cycle(); while (syndrome_ack);
    endtask

    task automatic check_round(input uf_pkg::syndrome_t s);
        uf_pkg::correction_t expected_correction;
        int                  expected_iterations;
        logic                upper;
        predict(s, expected_correction, expected_iterations);
        compare_value("correction", expected_correction, correction);
        compare_value("iteration_count", expected_iterations, iteration_count);
        // The round runs from loading, one cycle after ack rose, until result_valid rises
        compare_value("cycle_count", cycle_number - ack_cycle - 1, cycle_count);
        // Each defect sits between exactly one corrected edge
        for (int i = 0; i < N; i++) begin
            upper = (i + 1 < N) ? correction[i+1] : 1'b0;
            compare_value($sformatf("syndrome[%0d] from correction", i), s[i],
                          correction[i] ^ upper);
        end
        idle_cycles = cycle_count;
    endtask

    task automatic decode_round(input uf_pkg::syndrome_t s);
        send_syndrome(s);
        while (!result_valid) next_cycle();
        check_round(s);
    endtask

    task automatic blocked_request(input uf_pkg::syndrome_t first, input uf_pkg::syndrome_t second);
        logic seen_valid;
        send_syndrome(first);
        syndrome_in = second;
        syndrome_req = 1'b1;
        seen_valid = 1'b0;
        do begin
            next_cycle();
            if (result_valid && !seen_valid) begin
                seen_valid = 1'b1;
                check_round(first);
            end else if (seen_valid) begin
                compare_value("cycle_count", idle_cycles, cycle_count);
            end
        end while (!syndrome_ack);
        ack_cycle = cycle_number;
        if (!seen_valid) begin
            error_count++;
            $display("** Error at %0t ns: request acknowledged while a round was running", $time);
        end
        syndrome_req = 1'b0;
        do next_cycle(); while (syndrome_ack);
        while (!result_valid) next_cycle();
        check_round(second);
    endtask

    function automatic uf_pkg::syndrome_t random_syndrome();
        uf_pkg::syndrome_t s;
        s = uf_pkg::syndrome_t'($urandom);
        if ($urandom_range(0, 1) == 1) s &= uf_pkg::syndrome_t'($urandom);
        return s;
    endfunction

    // ##################################################
    // Test sequence

    initial begin
        void'($urandom(32'h8c0f_46c1));
        error_count = 0;
        idle_cycles = '0;
        cycle_number = 0;
        ack_cycle = 0;
        reset = 1'b1;
        syndrome_req = 1'b0;
        syndrome_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        compare_value("result_valid", 0, result_valid);
        compare_value("syndrome_ack", 0, syndrome_ack);
        compare_value("correction", 0, correction);
        compare_value("iteration_count", 0, iteration_count);
        compare_value("cycle_count", 0, cycle_count);

        decode_round('0);
        compare_value("correction", 0, correction);
        compare_value("iteration_count", 1, iteration_count);
        decode_round(uf_pkg::syndrome_t'(1));
        compare_value("correction", 1, correction);

        blocked_request(random_syndrome(), random_syndrome());

        for (int r = 0; r < RANDOM_ROUNDS; r++) begin
            decode_round(random_syndrome());
        end

        repeat (4) next_cycle();
        $display("Errors: %0d", total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS + RESET_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the decoder did not finish all rounds in time");
        $display("Errors: %0d", total_errors());
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
uf_pkg.sv
uf_array_if.sv
syndrome_intake.sv
unified_controller.sv
processing_unit.sv
pu_chain.sv
uf_decoder_top.sv
uf_decoder_sva.sv
tb_uf_decoder.sv

/* Bender.yml */
package:
  name: uf_decoder

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uf_pkg.sv
      - uf_array_if.sv
      - syndrome_intake.sv
      - unified_controller.sv
      - processing_unit.sv
      - pu_chain.sv
      - uf_decoder_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - uf_decoder_sva.sv
      - tb_uf_decoder.sv
